//--- Bender.yml
package:
  name: mult_core

export_include_dirs:
  - .

sources:
  - tomasulo_pkg.sv
  - mult_decode.sv
  - mult_issue_queue.sv
  - mult_execute.sv
  - mult_result.sv
  - mult_core_top.sv
  - target: simulation
    files:
      - tb_mult_core.sv

//--- build.f
+incdir+.
tomasulo_pkg.sv
mult_decode.sv
mult_issue_queue.sv
mult_execute.sv
mult_result.sv
mult_core_top.sv
tb_mult_core.sv

//--- mult_consts.svh
`ifndef MULT_CONSTS_SVH
`define MULT_CONSTS_SVH

// architectural register file size, r0 is not hardwired
`define NUM_REGS 8

// reservation entries in the shifting queue
`define QUEUE_DEPTH 4

// multiplier stages from issue to exec_valid
`define MULT_LATENCY 3

// producer tag width, the tag counter wraps at this size
`define TAG_BITS 6

`endif

//--- mult_core_top.sv
`timescale 1ns/1ns

module mult_core_top (
   input  logic                 clk,
   input  logic                 rst_n,
   input  tomasulo_pkg::instr_u instr,
   input  logic                 instr_valid,
   output logic                 instr_ready,
   output logic                 cdb_req,
   input  logic                 cdb_ack,
   output tomasulo_pkg::cdb_t   cdb_out
);
   import tomasulo_pkg::*;

   queue_entry_t disp_entry;
   logic         disp_valid;
   logic         disp_ready;
   issue_op_t    issue_op;
   logic         issue_ready;
   logic         issue_done;
   logic         exec_stall;
   logic         exec_valid;
   cdb_t         exec_result;
   // internal broadcast to rename and queue
   cdb_t         cdb;

   mult_decode u_decode (
      .clk, .rst_n, .instr, .instr_valid, .instr_ready,
      .disp_entry, .disp_valid, .disp_ready, .cdb
   );

   mult_issue_queue u_queue (
      .clk, .rst_n, .disp_entry, .disp_valid, .disp_ready,
      .cdb, .issue_op, .issue_ready, .issue_done
   );

   mult_execute u_execute (
      .clk, .rst_n, .issue_op, .issue_ready, .issue_done,
      .exec_stall, .exec_valid, .exec_result
   );

   mult_result u_result (
      .clk, .rst_n, .exec_valid, .exec_result, .exec_stall,
      .cdb_req, .cdb_ack, .cdb_out, .cdb
   );

endmodule

//--- mult_decode.sv
`timescale 1ns/1ns
`include "mult_consts.svh"

module mult_decode (
   input  logic                       clk,
   input  logic                       rst_n,
   input  tomasulo_pkg::instr_u       instr,
   input  logic                       instr_valid,
   output logic                       instr_ready,
   output tomasulo_pkg::queue_entry_t disp_entry,
   output logic                       disp_valid,
   input  logic                       disp_ready,
   input  tomasulo_pkg::cdb_t         cdb
);
   import tomasulo_pkg::*;

   // architectural state and register status table
   word_t                regs     [`NUM_REGS];
   tag_t                 stat_tag [`NUM_REGS];
   logic [`NUM_REGS-1:0] pending;
   tag_t                 next_tag;

   // operand 0 is rs, operand 1 is rt
   reg_idx_t src       [2];
   word_t    src_data  [2];
   tag_t     src_tag   [2];
   logic     src_valid [2];

   logic  is_mul;
   logic  is_ldi;
   logic  tag_busy;
   logic  mul_fire;
   logic  ldi_fire;
   word_t imm_ext;

   // both views read the same opcode bits
   assign is_mul  = (instr.r.opcode == OP_MUL);
   assign is_ldi  = (instr.i.opcode == OP_LDI);
   assign imm_ext = {{16{instr.i.imm[15]}}, instr.i.imm};

   // next tag must not still be owned by a waiting register
   always_comb begin
      tag_busy = 1'b0;
      for (int r = 0; r < `NUM_REGS; r++) begin
         if (pending[r] && stat_tag[r] == next_tag)
            tag_busy = 1'b1;
      end
   end

   // rename lookup, a broadcast in this same cycle bypasses the table
   always_comb begin
      src[0] = instr.r.rs;
      src[1] = instr.r.rt;
      for (int s = 0; s < 2; s++) begin
         src_tag[s] = stat_tag[src[s]];
         if (!pending[src[s]]) begin
            src_data[s]  = regs[src[s]];
            src_valid[s] = 1'b1;
         end else if (cdb.valid && cdb.tag == stat_tag[src[s]]) begin
            src_data[s]  = cdb.data;
            src_valid[s] = 1'b1;
         end else begin
            src_data[s]  = '0;
            src_valid[s] = 1'b0;
         end
      end
   end

   // non-mul words never wait
   assign instr_ready = is_mul ? (disp_ready & ~tag_busy) : 1'b1;
   assign disp_valid  = instr_valid & is_mul & ~tag_busy;
   assign mul_fire    = disp_valid & disp_ready;
   assign ldi_fire    = instr_valid & is_ldi;

   assign disp_entry = '{dst_tag:  next_tag,
                         rs_tag:   src_tag[0],
                         rt_tag:   src_tag[1],
                         rs_data:  src_data[0],
                         rt_data:  src_data[1],
                         rs_valid: src_valid[0],
                         rt_valid: src_valid[1]};

   // register data and status tags, ldi is younger than any broadcast
   always_ff @(posedge clk) begin
      for (int r = 0; r < `NUM_REGS; r++) begin
         if (cdb.valid && pending[r] && stat_tag[r] == cdb.tag)
            regs[r] <= cdb.data;
      end
      if (ldi_fire)
         regs[instr.i.rd] <= imm_ext;
      if (mul_fire)
         stat_tag[instr.r.rd] <= next_tag;
   end

   // pending bits and the wrapping tag counter
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pending  <= '0;
         next_tag <= '0;
      end else begin
         for (int r = 0; r < `NUM_REGS; r++) begin
            if (cdb.valid && pending[r] && stat_tag[r] == cdb.tag)
               pending[r] <= 1'b0;
         end
         if (ldi_fire)
            pending[instr.i.rd] <= 1'b0;
         // new producer overrides a same-cycle wakeup of rd
         if (mul_fire) begin
            pending[instr.r.rd] <= 1'b1;
            next_tag            <= next_tag + 1'b1;
         end
      end
   end

endmodule

//--- mult_execute.sv
`timescale 1ns/1ns
`include "mult_consts.svh"

module mult_execute (
   input  logic                    clk,
   input  logic                    rst_n,
   input  tomasulo_pkg::issue_op_t issue_op,
   input  logic                    issue_ready,
   output logic                    issue_done,
   input  logic                    exec_stall,
   output logic                    exec_valid,
   output tomasulo_pkg::cdb_t      exec_result
);
   import tomasulo_pkg::*;

   logic [`MULT_LATENCY:1] vld_r;
   tag_t                   tag_r  [`MULT_LATENCY:1];
   word_t                  prod_r [`MULT_LATENCY:2];
   // stage 1 partial products
   word_t                  pp_lo_r;
   logic [15:0]            pp_hi_r;
   logic                   advance;

   // one stall freezes every stage
   assign advance    = ~exec_stall;
   assign issue_done = advance;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         vld_r <= '0;
      else if (advance)
         vld_r <= {vld_r[`MULT_LATENCY-1:1], issue_ready};
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         tag_r[1] <= issue_op.dst_tag;
         // rs * rt_lo, full low word
         pp_lo_r  <= issue_op.rs_data * issue_op.rt_data[15:0];
         // rs_lo * rt_hi, only the low half lands in the result
         pp_hi_r  <= issue_op.rs_data[15:0] * issue_op.rt_data[31:16];
         prod_r[2] <= pp_lo_r + {pp_hi_r, 16'h0000};
         for (int s = 2; s <= `MULT_LATENCY; s++)
            tag_r[s] <= tag_r[s-1];
         // remaining stages only delay the product
         for (int s = 3; s <= `MULT_LATENCY; s++)
            prod_r[s] <= prod_r[s-1];
      end
   end

   assign exec_valid  = vld_r[`MULT_LATENCY];
   assign exec_result = '{valid: vld_r[`MULT_LATENCY],
                          tag:   tag_r[`MULT_LATENCY],
                          data:  prod_r[`MULT_LATENCY]};

endmodule

//--- mult_issue_queue.sv
`timescale 1ns/1ns
`include "mult_consts.svh"

module mult_issue_queue (
   input  logic                       clk,
   input  logic                       rst_n,
   input  tomasulo_pkg::queue_entry_t disp_entry,
   input  logic                       disp_valid,
   output logic                       disp_ready,
   input  tomasulo_pkg::cdb_t         cdb,
   output tomasulo_pkg::issue_op_t    issue_op,
   output logic                       issue_ready,
   input  logic                       issue_done
);
   import tomasulo_pkg::*;

   // slots 1..QUEUE_DEPTH are flops, the top slot holds the oldest entry
   queue_entry_t            ent_r [`QUEUE_DEPTH:1];
   logic [`QUEUE_DEPTH:1]   vld_r;

   // slot 0 is the incoming dispatch, no flops behind it
   queue_entry_t            ent     [`QUEUE_DEPTH:0];
   queue_entry_t            woke    [`QUEUE_DEPTH:0];
   queue_entry_t            ent_nxt [`QUEUE_DEPTH:1];
   logic [`QUEUE_DEPTH:0]   vld;
   logic [`QUEUE_DEPTH:0]   sel;
   logic [`QUEUE_DEPTH:0]   leave;
   logic [`QUEUE_DEPTH+1:1] do_shift;
   logic [`QUEUE_DEPTH:1]   vld_nxt;
   logic                    any_ready;
   logic                    full_above;
   logic                    sel_above;

   always_comb begin
      ent[0] = disp_entry;
      vld[0] = disp_valid;
      for (int k = 1; k <= `QUEUE_DEPTH; k++) begin
         ent[k] = ent_r[k];
         vld[k] = vld_r[k];
      end
   end

   // cdb snoop on every slot, incoming one included
   always_comb begin
      for (int k = 0; k <= `QUEUE_DEPTH; k++) begin
         woke[k] = ent[k];
         if (cdb.valid && !ent[k].rs_valid && cdb.tag == ent[k].rs_tag) begin
            woke[k].rs_data  = cdb.data;
            woke[k].rs_valid = 1'b1;
         end
         if (cdb.valid && !ent[k].rt_valid && cdb.tag == ent[k].rt_tag) begin
            woke[k].rt_data  = cdb.data;
            woke[k].rt_valid = 1'b1;
         end
      end
   end

   // oldest ready wins, judged on registered operand flags only
   always_comb begin
      sel       = '0;
      any_ready = 1'b0;
      for (int k = `QUEUE_DEPTH; k >= 1; k--) begin
         if (!any_ready && vld[k] && ent[k].rs_valid && ent[k].rt_valid) begin
            sel[k]    = 1'b1;
            any_ready = 1'b1;
         end
      end
      leave = sel & {(`QUEUE_DEPTH+1){issue_done}};
   end

   assign issue_ready = any_ready;

   // falls back to the top slot when nothing is ready
   always_comb begin
      issue_op = '{dst_tag: ent[`QUEUE_DEPTH].dst_tag,
                   rs_data: ent[`QUEUE_DEPTH].rs_data,
                   rt_data: ent[`QUEUE_DEPTH].rt_data};
      for (int k = 1; k <= `QUEUE_DEPTH; k++) begin
         if (sel[k])
            issue_op = '{dst_tag: ent[k].dst_tag,
                         rs_data: ent[k].rs_data,
                         rt_data: ent[k].rt_data};
      end
   end

   // slot k takes slot k-1 when there is room at or above k
   // room means a hole or the selected entry leaving this cycle
   always_comb begin
      full_above = 1'b1;
      sel_above  = 1'b0;
      // nothing sits above the top slot
      do_shift[`QUEUE_DEPTH+1] = 1'b0;
      for (int k = `QUEUE_DEPTH; k >= 1; k--) begin
         full_above  = full_above & vld[k];
         sel_above   = sel_above | sel[k];
         do_shift[k] = vld[k-1] & ((issue_done & sel_above) | ~full_above) & ~leave[k-1];
      end
      for (int k = 1; k <= `QUEUE_DEPTH; k++) begin
         ent_nxt[k] = do_shift[k] ? woke[k-1] : woke[k];
         // stays valid if filled from below, or kept and not moved up
         vld_nxt[k] = do_shift[k] | (vld[k] & ~leave[k] & ~do_shift[k+1]);
      end
   end

   // full only if every slot is taken and none leaves now
   assign disp_ready = ~((&vld_r) & ~(issue_done & any_ready));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         vld_r <= '0;
      else
         vld_r <= vld_nxt;
   end

   always_ff @(posedge clk) begin
      for (int k = 1; k <= `QUEUE_DEPTH; k++)
         ent_r[k] <= ent_nxt[k];
   end

endmodule

//--- mult_result.sv
`timescale 1ns/1ns

module mult_result (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               exec_valid,
   input  tomasulo_pkg::cdb_t exec_result,
   output logic               exec_stall,
   output logic               cdb_req,
   input  logic               cdb_ack,
   output tomasulo_pkg::cdb_t cdb_out,
   output tomasulo_pkg::cdb_t cdb
);
   import tomasulo_pkg::*;

   // four-phase handshake with the outside arbiter
   typedef enum logic [1:0] {
      RS_IDLE,
      RS_REQ,
      RS_RELEASE
   } res_state_e;

   res_state_e state_r;
   logic       full_r;
   tag_t       hold_tag_r;
   word_t      hold_data_r;
   logic       capture;
   logic       bcast;

   assign capture    = exec_valid & ~full_r;
   // first ack cycle is the broadcast
   assign bcast      = (state_r == RS_REQ) & cdb_ack;
   assign exec_stall = full_r;
   assign cdb_req    = (state_r == RS_REQ);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_r <= RS_IDLE;
         full_r  <= 1'b0;
      end else begin
         if (capture)
            full_r <= 1'b1;
         else if (bcast)
            full_r <= 1'b0;
         case (state_r)
            RS_IDLE:    if (capture) state_r <= RS_REQ;
            RS_REQ:     if (cdb_ack) state_r <= RS_RELEASE;
            // next request only after ack drops
            RS_RELEASE: if (!cdb_ack) state_r <= (full_r | capture) ? RS_REQ : RS_IDLE;
            default:    state_r <= RS_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (capture) begin
         hold_tag_r  <= exec_result.tag;
         hold_data_r <= exec_result.data;
      end
   end

   // data stays stable for the whole request
   assign cdb_out = '{valid: cdb_req, tag: hold_tag_r, data: hold_data_r};
   assign cdb     = '{valid: bcast, tag: hold_tag_r, data: hold_data_r};

endmodule

//--- tb_mult_core.sv
`timescale 1ns/1ns
`include "mult_consts.svh"

module tb_mult_core;
   import tomasulo_pkg::*;

   // cycles allowed for any single wait
   localparam int TIMEOUT = 200;

   logic   clk;
   logic   rst_n;
   instr_u instr;
   logic   instr_valid;
   logic   instr_ready;
   logic   cdb_req;
   logic   cdb_ack;
   cdb_t   cdb_out;

   // reference model of register values in program order and the tag counter
   word_t  ref_regs [`NUM_REGS];
   tag_t   ref_tag;
   // expected broadcasts with the oldest at the front
   cdb_t   exp_q [$];

   integer seed;
   int     checks;
   int     errors;
   int     test_errors;

   mult_core_top DUT (
      .clk, .rst_n, .instr, .instr_valid, .instr_ready,
      .cdb_req, .cdb_ack, .cdb_out
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic compare_bit(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0t ns: %s expected %b got %b", $time, what, exp, got);
      end
   endtask

   task automatic compare_cdb(input cdb_t got, input cdb_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0t ns: %s expected tag %0d data %h got valid %b tag %0d data %h",
                  $time, what, exp.tag, exp.data, got.valid, got.tag, got.data);
      end
   endtask

   function automatic instr_u mul_word(input reg_idx_t rd, input reg_idx_t rs,
                                       input reg_idx_t rt);
      instr_u w;
      w          = '0;
      w.r.opcode = OP_MUL;
      w.r.rd     = rd;
      w.r.rs     = rs;
      w.r.rt     = rt;
      return w;
   endfunction

   function automatic instr_u ldi_word(input reg_idx_t rd, input logic [15:0] imm);
      instr_u w;
      w          = '0;
      w.i.opcode = OP_LDI;
      w.i.rd     = rd;
      w.i.imm    = imm;
      return w;
   endfunction

   function automatic logic [15:0] rand_imm();
      word_t r;
      r = $random(seed);
      return r[15:0];
   endfunction

   // sources come from r0..r3 and destinations from r4..r7 so no MUL feeds another
   function automatic reg_idx_t rand_src();
      word_t r;
      r = $random(seed);
      return {1'b0, r[1:0]};
   endfunction

   function automatic reg_idx_t rand_dst();
      word_t r;
      r = $random(seed);
      return {1'b1, r[1:0]};
   endfunction

   // called on a falling edge and holds the word until a rising edge sees instr_ready
   task automatic send_instr(input instr_u w);
      int n;
      n           = 0;
      instr       = w;
      instr_valid = 1'b1;
      do begin
         @(posedge clk);
         n++;
      end while (!instr_ready && n < TIMEOUT);
      if (!instr_ready) begin
         errors++;
         $display("instruction %h was never accepted, timeout at %0t ns", w, $time);
      end
      @(negedge clk);
      instr_valid = 1'b0;
   endtask

   // sign-extended immediate lands in rd
   task automatic load_imm(input reg_idx_t rd, input logic [15:0] imm);
      ref_regs[rd] = {{16{imm[15]}}, imm};
      send_instr(ldi_word(rd, imm));
   endtask

   // low 32 bits of rs * rt tagged with the next counter value
   task automatic issue_mul(input reg_idx_t rd, input reg_idx_t rs, input reg_idx_t rt);
      cdb_t exp;
      exp.valid    = 1'b1;
      exp.tag      = ref_tag;
      exp.data     = ref_regs[rs] * ref_regs[rt];
      ref_regs[rd] = exp.data;
      ref_tag++;
      exp_q.push_back(exp);
      send_instr(mul_word(rd, rs, rt));
   endtask

   // four-phase grant with req seen, then a delay, ack up, req down and ack down
   task automatic arbiter_grant(input int delay, output cdb_t got);
      int n;
      got = '0;
      n   = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!cdb_req && n < TIMEOUT);
      if (!cdb_req) begin
         errors++;
         $display("cdb_req was never raised, timeout at %0t ns", $time);
      end else begin
         repeat (delay) begin
            @(posedge clk);
            compare_bit(cdb_req, 1'b1, "cdb_req before ack");
         end
         @(negedge clk);
         cdb_ack = 1'b1;
         // first ack cycle carries the broadcast
         @(posedge clk);
         got = cdb_out;
         n   = 0;
         do begin
            @(posedge clk);
            n++;
         end while (cdb_req && n < TIMEOUT);
         if (cdb_req) begin
            errors++;
            $display("cdb_req stayed high after ack, timeout at %0t ns", $time);
         end
         @(negedge clk);
         cdb_ack = 1'b0;
      end
   endtask

   task automatic collect_results(input int count);
      cdb_t  got;
      cdb_t  exp;
      word_t r;
      for (int i = 0; i < count; i++) begin
         r = $random(seed);
         arbiter_grant(r % 4, got);
         if (exp_q.size() == 0) begin
            errors++;
            $display("broadcast of tag %0d at %0t ns had no instruction", got.tag, $time);
         end else begin
            exp = exp_q.pop_front();
            compare_cdb(got, exp, "cdb_out");
         end
      end
   endtask

   task automatic end_test(input string name);
      $display("test %-12s done, %0d errors", name, errors - test_errors);
      test_errors = errors;
      exp_q.delete();
   endtask

   // a MUL word with valid low must still see instr_ready high
   task automatic test_reset();
      instr = mul_word(3'd1, 3'd2, 3'd3);
      @(posedge clk);
      compare_bit(instr_ready, 1'b1, "instr_ready after reset");
      compare_bit(cdb_req, 1'b0, "cdb_req after reset");
      @(negedge clk);
      instr = '0;
      end_test("reset");
   endtask

   task automatic test_ldi_mul();
      @(negedge clk);
      load_imm(3'd1, rand_imm());
      load_imm(3'd2, rand_imm());
      issue_mul(3'd3, 3'd1, 3'd2);
      collect_results(1);
      end_test("ldi_mul");
   endtask

   // r4 reads r3 while its producer is still in flight
   task automatic test_chain();
      @(negedge clk);
      // a fresh r2 makes the new r3 differ from the value left in the register file
      load_imm(3'd2, rand_imm());
      issue_mul(3'd3, 3'd1, 3'd2);
      issue_mul(3'd4, 3'd3, 3'd1);
      collect_results(2);
      end_test("chain");
   endtask

   task automatic test_ordering();
      reg_idx_t dst [6];
      reg_idx_t rs  [6];
      reg_idx_t rt  [6];
      @(negedge clk);
      for (int r = 0; r < 4; r++)
         load_imm(r[2:0], rand_imm());
      // registers of the six independent MULs
      for (int n = 0; n < 6; n++) begin
         dst[n] = rand_dst();
         rs[n]  = rand_src();
         rt[n]  = rand_src();
      end
      fork
         for (int n = 0; n < 6; n++)
            issue_mul(dst[n], rs[n], rt[n]);
         collect_results(6);
      join
      end_test("ordering");
   endtask

   task automatic test_backpressure();
      int       cap;
      reg_idx_t dst;
      reg_idx_t rs;
      reg_idx_t rt;
      // queue slots, multiplier stages and the result holding register
      cap = `QUEUE_DEPTH + `MULT_LATENCY + 1;
      @(negedge clk);
      for (int n = 0; n < cap; n++) begin
         dst = rand_dst();
         rs  = rand_src();
         rt  = rand_src();
         issue_mul(dst, rs, rt);
      end
      // one more word waits while no ack comes
      instr       = mul_word(3'd7, 3'd0, 3'd1);
      instr_valid = 1'b1;
      repeat (8) begin
         @(posedge clk);
         compare_bit(instr_ready, 1'b0, "instr_ready with cluster full");
         compare_bit(cdb_req, 1'b1, "cdb_req without ack");
      end
      @(negedge clk);
      fork
         issue_mul(3'd7, 3'd0, 3'd1);
         collect_results(cap + 1);
      join
      end_test("backpressure");
   endtask

   // r5 is overwritten by LDI while its MUL is pending
   task automatic test_ldi_overwrite();
      @(negedge clk);
      issue_mul(3'd5, 3'd1, 3'd2);
      load_imm(3'd5, rand_imm());
      issue_mul(3'd6, 3'd5, 3'd1);
      issue_mul(3'd7, 3'd5, 3'd5);
      collect_results(3);
      end_test("ldi_overwrite");
   endtask

   initial begin
      seed        = 32'h012570f9;
      rst_n       = 1'b0;
      instr       = '0;
      instr_valid = 1'b0;
      cdb_ack     = 1'b0;
      ref_tag     = '0;
      checks      = 0;
      errors      = 0;
      test_errors = 0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      test_reset();
      test_ldi_mul();
      test_chain();
      test_ordering();
      test_backpressure();
      test_ldi_overwrite();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

//--- tomasulo_pkg.sv
`include "mult_consts.svh"

package tomasulo_pkg;

   typedef logic [31:0]                     word_t;
   typedef logic [`TAG_BITS-1:0]            tag_t;
   typedef logic [$clog2(`NUM_REGS)-1:0]    reg_idx_t;

   // any other opcode is accepted and dropped at decode
   typedef enum logic [3:0] {
      OP_MUL = 4'h1,
      OP_LDI = 4'h2
   } opcode_e;

   // register form, rd = rs * rt
   typedef struct packed {
      opcode_e     opcode;
      reg_idx_t    rd;
      reg_idx_t    rs;
      reg_idx_t    rt;
      logic [18:0] pad;
   } r_format_t;

   // immediate form, rd = sext(imm)
   typedef struct packed {
      opcode_e     opcode;
      reg_idx_t    rd;
      logic [8:0]  pad;
      logic [15:0] imm;
   } i_format_t;

   // opcode and rd share bit positions in both views
   typedef union packed {
      r_format_t r;
      i_format_t i;
   } instr_u;

   typedef struct packed {
      tag_t  dst_tag;
      tag_t  rs_tag;
      tag_t  rt_tag;
      word_t rs_data;
      word_t rt_data;
      logic  rs_valid;
      logic  rt_valid;
   } queue_entry_t;

   typedef struct packed {
      tag_t  dst_tag;
      word_t rs_data;
      word_t rt_data;
   } issue_op_t;

   typedef struct packed {
      logic  valid;
      tag_t  tag;
      word_t data;
   } cdb_t;

endpackage
